//--- project.f
src/alu_opcode_pkg.sv
src/alu_data_pkg.sv
src/seq_op_if.sv
src/serial_addsub.sv
src/shift_add_multiplier.sv
src/restoring_divider.sv
src/logic_compare_unit.sv
src/alu_dispatch.sv
src/alu_top.sv
testbench/alu_tb.sv

//--- src/alu_data_pkg.sv
package alu_data_pkg;

    // Operand width
    localparam int WIDTH = 8;

    // Bit-step counter, must reach WIDTH
    localparam int COUNT_W = $clog2(WIDTH + 1);

    // One operand or one half of a result
    typedef logic [WIDTH-1:0] word_t;

    // Two-word view of a result
    typedef struct packed {
        word_t high;
        word_t low;
    } word_pair_t;

    // Same 2*WIDTH bits seen either as a full product
    // or as a high/low pair (quotient and remainder, or a single low word)
    typedef union packed {
        logic [2*WIDTH-1:0] product;
        word_pair_t words;
    } result_u;

endpackage

//--- src/alu_dispatch.sv
`timescale 1ns/1ns

module alu_dispatch (
    input logic clk,
    input logic reset,
    input logic start,
    input alu_opcode_pkg::opcode_t opcode,
    input alu_data_pkg::word_t in1,
    input alu_data_pkg::word_t in2,
    seq_op_if.dispatch addsub_bus,
    seq_op_if.dispatch mul_bus,
    seq_op_if.dispatch div_bus,
    input alu_data_pkg::word_t comb_result,
    input logic comb_flag,
    output alu_data_pkg::word_t out_high,
    output alu_data_pkg::word_t out_low,
    output logic flag,
    output logic done
);
    import alu_data_pkg::*;
    import alu_opcode_pkg::*;

    // Control state
    logic waiting;
    logic finishing;
    logic launch;
    logic accept;
    op_group_t grp_in;
    op_group_t grp_q;
    opcode_t op_q;

    // Latched operands for the unit
    word_t a_q;
    word_t b_q;

    // Result staged one cycle ahead of done
    word_t cap_high;
    word_t cap_low;
    logic cap_flag;

    // Response of the active unit
    result_u unit_result;
    logic unit_flag;
    logic unit_done;

    assign grp_in = op_group(opcode);
    // Start is ignored while an op is in flight
    assign accept = start && !waiting && !finishing;

    // Exactly one unit sees a start pulse
    assign addsub_bus.start = launch && (grp_q == GROUP_ADDSUB);
    assign addsub_bus.operand_a = a_q;
    assign addsub_bus.operand_b = b_q;
    assign addsub_bus.sub_mode = (op_q == SUB);

    assign mul_bus.start = launch && (grp_q == GROUP_MUL);
    assign mul_bus.operand_a = a_q;
    assign mul_bus.operand_b = b_q;
    assign mul_bus.sub_mode = 1'b0;

    assign div_bus.start = launch && (grp_q == GROUP_DIV);
    assign div_bus.operand_a = a_q;
    assign div_bus.operand_b = b_q;
    assign div_bus.sub_mode = 1'b0;

    // Pick the response of the latched group
    always_comb begin
        unit_result = '0;
        unit_flag = 1'b0;
        unit_done = 1'b0;
        case (grp_q)
            GROUP_ADDSUB: begin
                unit_result = addsub_bus.result;
                unit_flag = addsub_bus.flag;
                unit_done = addsub_bus.done;
            end
            GROUP_MUL: begin
                unit_result = mul_bus.result;
                unit_flag = mul_bus.flag;
                unit_done = mul_bus.done;
            end
            GROUP_DIV: begin
                unit_result = div_bus.result;
                unit_flag = div_bus.flag;
                unit_done = div_bus.done;
            end
            default: unit_done = 1'b0;
        endcase
    end

    // Sequencing and registered outputs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            waiting <= 1'b0;
            finishing <= 1'b0;
            launch <= 1'b0;
            grp_q <= GROUP_NONE;
            op_q <= ADD;
            out_high <= '0;
            out_low <= '0;
            flag <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            launch <= 1'b0;
            if (accept) begin
                op_q <= opcode;
                grp_q <= grp_in;
                // Comb and unsupported ops answer on the next edge
                if (grp_in == GROUP_COMB || grp_in == GROUP_NONE) begin
                    finishing <= 1'b1;
                end else begin
                    waiting <= 1'b1;
                    launch <= 1'b1;
                end
            end else if (waiting && unit_done) begin
                waiting <= 1'b0;
                finishing <= 1'b1;
            end else if (finishing) begin
                finishing <= 1'b0;
                done <= 1'b1;
                out_high <= cap_high;
                out_low <= cap_low;
                flag <= cap_flag;
            end
        end
    end

    // Operand latch and result capture
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= in1;
            b_q <= in2;
            cap_high <= '0;
            cap_low <= (grp_in == GROUP_COMB) ? comb_result : '0;
            cap_flag <= (grp_in == GROUP_COMB) ? comb_flag : 1'b0;
        end else if (waiting && unit_done) begin
            cap_high <= unit_result.words.high;
            cap_low <= unit_result.words.low;
            cap_flag <= unit_flag;
        end
    end

endmodule

//--- src/alu_opcode_pkg.sv
package alu_opcode_pkg;

    // Opcode field width on the top-level port
    localparam int OPCODE_W = 4;

    // Supported opcodes
    // 4, 5 and 13 to 15 are unsupported and complete with zeros
    typedef enum logic [OPCODE_W-1:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        MUL = 4'd2,
        DIV = 4'd3,
        LT  = 4'd6,
        GT  = 4'd7,
        EQ  = 4'd8,
        AND = 4'd9,
        OR  = 4'd10,
        XOR = 4'd11,
        NOT = 4'd12
    } opcode_t;

    // Which execution unit serves an opcode
    typedef enum logic [2:0] {
        GROUP_ADDSUB,
        GROUP_MUL,
        GROUP_DIV,
        GROUP_COMB,
        GROUP_NONE
    } op_group_t;

    // Map an opcode onto its unit group
    function automatic op_group_t op_group(opcode_t op);
        case (op)
            ADD, SUB: return GROUP_ADDSUB;
            MUL: return GROUP_MUL;
            DIV: return GROUP_DIV;
            LT, GT, EQ, AND, OR, XOR, NOT: return GROUP_COMB;
            default: return GROUP_NONE;
        endcase
    endfunction

endpackage

//--- src/alu_top.sv
`timescale 1ns/1ns

module alu_top (
    input logic clk,
    input logic reset,
    input logic start,
    input logic [alu_opcode_pkg::OPCODE_W-1:0] opcode,
    input alu_data_pkg::word_t in1,
    input alu_data_pkg::word_t in2,
    output alu_data_pkg::word_t out_high,
    output alu_data_pkg::word_t out_low,
    output logic flag,
    output logic done
);
    import alu_data_pkg::*;
    import alu_opcode_pkg::*;

    // Raw opcode seen as the enum, unsupported codes included
    opcode_t opcode_e;
    word_t comb_result;
    logic comb_flag;

    assign opcode_e = opcode_t'(opcode);

    // One link per multi-cycle unit
    seq_op_if addsub_bus ();
    seq_op_if mul_bus ();
    seq_op_if div_bus ();

    alu_dispatch i_alu_dispatch (
        .clk(clk),
        .reset(reset),
        .start(start),
        .opcode(opcode_e),
        .in1(in1),
        .in2(in2),
        .addsub_bus(addsub_bus.dispatch),
        .mul_bus(mul_bus.dispatch),
        .div_bus(div_bus.dispatch),
        .comb_result(comb_result),
        .comb_flag(comb_flag),
        .out_high(out_high),
        .out_low(out_low),
        .flag(flag),
        .done(done)
    );

    serial_addsub i_serial_addsub (
        .clk(clk),
        .reset(reset),
        .bus(addsub_bus.unit)
    );

    shift_add_multiplier i_shift_add_multiplier (
        .clk(clk),
        .reset(reset),
        .bus(mul_bus.unit)
    );

    restoring_divider i_restoring_divider (
        .clk(clk),
        .reset(reset),
        .bus(div_bus.unit)
    );

    // Sees live inputs, dispatcher samples it on the start edge
    logic_compare_unit i_logic_compare_unit (
        .opcode(opcode_e),
        .in1(in1),
        .in2(in2),
        .result(comb_result),
        .flag(comb_flag)
    );

endmodule

//--- src/logic_compare_unit.sv
`timescale 1ns/1ns

module logic_compare_unit (
    input alu_opcode_pkg::opcode_t opcode,
    input alu_data_pkg::word_t in1,
    input alu_data_pkg::word_t in2,
    output alu_data_pkg::word_t result,
    output logic flag
);
    import alu_opcode_pkg::*;

    // Single-cycle ops, everything else reads as zero
    always_comb begin
        result = '0;
        flag = 1'b0;
        case (opcode)
            // Bitwise ops to the word
            AND: result = in1 & in2;
            OR: result = in1 | in2;
            XOR: result = in1 ^ in2;
            NOT: result = ~in1;
            // Unsigned compares to the flag
            LT: flag = (in1 < in2);
            GT: flag = (in1 > in2);
            EQ: flag = (in1 == in2);
            default: begin
                result = '0;
                flag = 1'b0;
            end
        endcase
    end

endmodule

//--- src/restoring_divider.sv
`timescale 1ns/1ns

module restoring_divider (
    input logic clk,
    input logic reset,
    seq_op_if.unit bus
);
    import alu_data_pkg::*;

    // Control state
    logic busy;
    logic finish;
    logic [COUNT_W-1:0] bit_count;
    logic last_bit;
    logic idle;
    logic divide_by_zero;

    // Divisor, partial remainder, and dividend turning into quotient
    word_t divisor_q;
    word_t rem_q;
    word_t quo_q;

    // Trial subtraction, one extra bit for the shifted remainder
    // and one more to catch the borrow
    logic [WIDTH:0] shifted;
    logic [WIDTH+1:0] trial;
    logic borrow;

    assign idle = !busy && !finish;
    assign last_bit = (bit_count == COUNT_W'(WIDTH - 1));
    assign divide_by_zero = (bus.operand_b == '0);

    // Bring down next dividend bit
    assign shifted = {rem_q, quo_q[WIDTH-1]};
    assign trial = {1'b0, shifted} - {2'b00, divisor_q};
    assign borrow = trial[WIDTH+1];

    assign bus.flag = 1'b0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            finish <= 1'b0;
            bit_count <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (finish) begin
                finish <= 1'b0;
                bus.done <= 1'b1;
            end else if (busy) begin
                bit_count <= bit_count + 1'b1;
                if (last_bit) begin
                    busy <= 1'b0;
                    finish <= 1'b1;
                end
            end else if (bus.start) begin
                // Zero divisor skips the loop
                busy <= !divide_by_zero;
                finish <= divide_by_zero;
                bit_count <= '0;
            end
        end
    end

    // One quotient bit per cycle, MSB first
    always_ff @(posedge clk) begin
        if (idle && bus.start) begin
            divisor_q <= bus.operand_b;
            rem_q <= '0;
            quo_q <= divide_by_zero ? '0 : bus.operand_a;
        end else if (busy) begin
            quo_q <= {quo_q[WIDTH-2:0], ~borrow};
            // Keep the difference only when it did not go negative
            rem_q <= borrow ? shifted[WIDTH-1:0] : trial[WIDTH-1:0];
        end
        if (finish) begin
            bus.result.words.high <= quo_q;
            bus.result.words.low <= rem_q;
        end
    end

endmodule

//--- src/seq_op_if.sv
`timescale 1ns/1ns

// Link between the dispatcher and one multi-cycle unit
interface seq_op_if;
    import alu_data_pkg::*;

    // Request side, from the dispatcher
    logic start;
    word_t operand_a;
    word_t operand_b;
    logic sub_mode;

    // Response side, from the unit
    result_u result;
    logic flag;
    logic done;

    modport dispatch (
        output start, operand_a, operand_b, sub_mode,
        input result, flag, done
    );

    // Operands are sampled with start, result holds until next start
    modport unit (
        input start, operand_a, operand_b, sub_mode,
        output result, flag, done
    );

endinterface

//--- src/serial_addsub.sv
`timescale 1ns/1ns

module serial_addsub (
    input logic clk,
    input logic reset,
    seq_op_if.unit bus
);
    import alu_data_pkg::*;

    // Control state
    logic busy;
    logic store_phase;
    logic finish;
    logic [COUNT_W-1:0] bit_count;
    logic last_bit;
    logic idle;

    // Operand shifters, LSB goes first
    word_t a_q;
    word_t b_q;
    // Sum fills from the top and shifts down
    word_t sum_q;
    logic sub_q;

    // Full adder inputs, held for the store step
    logic bit_a;
    logic bit_b;
    logic carry_q;
    logic fa_sum;
    logic fa_carry;

    assign idle = !busy && !finish;
    assign last_bit = (bit_count == COUNT_W'(WIDTH - 1));

    // One-bit full adder
    assign fa_sum = bit_a ^ bit_b ^ carry_q;
    assign fa_carry = (bit_a & bit_b) | (carry_q & (bit_a ^ bit_b));

    // Load/store sequencing, two cycles per bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            store_phase <= 1'b0;
            finish <= 1'b0;
            bit_count <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (finish) begin
                finish <= 1'b0;
                bus.done <= 1'b1;
            end else if (busy) begin
                store_phase <= ~store_phase;
                if (store_phase) begin
                    bit_count <= bit_count + 1'b1;
                    // Last bit stored, wrap up next cycle
                    if (last_bit) begin
                        busy <= 1'b0;
                        finish <= 1'b1;
                    end
                end
            end else if (bus.start) begin
                busy <= 1'b1;
                store_phase <= 1'b0;
                bit_count <= '0;
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (idle && bus.start) begin
            a_q <= bus.operand_a;
            b_q <= bus.operand_b;
            sub_q <= bus.sub_mode;
            // Subtract is a + ~b + 1
            carry_q <= bus.sub_mode;
        end else if (busy && !store_phase) begin
            // Load step
            bit_a <= a_q[0];
            bit_b <= b_q[0] ^ sub_q;
            a_q <= a_q >> 1;
            b_q <= b_q >> 1;
        end else if (busy) begin
            // Store step
            sum_q <= {fa_sum, sum_q[WIDTH-1:1]};
            carry_q <= fa_carry;
        end
        if (finish) begin
            bus.result.words.high <= '0;
            bus.result.words.low <= sum_q;
            // No carry out of a + ~b + 1 means a < b
            bus.flag <= sub_q ? ~carry_q : carry_q;
        end
    end

endmodule

//--- src/shift_add_multiplier.sv
`timescale 1ns/1ns

module shift_add_multiplier (
    input logic clk,
    input logic reset,
    seq_op_if.unit bus
);
    import alu_data_pkg::*;

    // Control state
    logic busy;
    logic finish;
    logic [COUNT_W-1:0] bit_count;
    logic last_bit;
    logic idle;

    // Partial product and multiplicand, both double width
    logic [2*WIDTH-1:0] acc_q;
    logic [2*WIDTH-1:0] mcand_q;
    // Multiplier bits, consumed from bit 0
    word_t mplier_q;

    assign idle = !busy && !finish;
    assign last_bit = (bit_count == COUNT_W'(WIDTH - 1));

    // Never a carry or borrow here
    assign bus.flag = 1'b0;

    // One multiplier bit per cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            finish <= 1'b0;
            bit_count <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (finish) begin
                finish <= 1'b0;
                bus.done <= 1'b1;
            end else if (busy) begin
                bit_count <= bit_count + 1'b1;
                if (last_bit) begin
                    busy <= 1'b0;
                    finish <= 1'b1;
                end
            end else if (bus.start) begin
                busy <= 1'b1;
                bit_count <= '0;
            end
        end
    end

    // Shift-and-add datapath
    always_ff @(posedge clk) begin
        if (idle && bus.start) begin
            acc_q <= '0;
            mcand_q <= {{WIDTH{1'b0}}, bus.operand_a};
            mplier_q <= bus.operand_b;
        end else if (busy) begin
            // Add shifted multiplicand on a set bit
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
        if (finish) begin
            bus.result.product <= acc_q;
        end
    end

endmodule

//--- testbench/alu_tb.sv
`timescale 1ns/1ns

module alu_tb;
    import alu_data_pkg::*;
    import alu_opcode_pkg::*;

    // Cycles allowed between a start and its done
    localparam int DONE_TIMEOUT = 200;
    // Input skew after the rising edge
    localparam int DRIVE_DELAY = 1;
    // Idle cycles at the end to catch a stray done
    localparam int DRAIN_CYCLES = 20;

    // DUT ports
    logic clk;
    logic reset;
    logic start;
    logic [OPCODE_W-1:0] opcode;
    word_t in1;
    word_t in2;
    word_t out_high;
    word_t out_low;
    logic flag;
    logic done;

    // Bookkeeping
    int test_count = 0;
    int pass_count = 0;
    int fail_count = 0;
    int other_errors = 0;
    int done_count = 0;
    logic timed_out = 1'b0;

    alu_top i_alu_top (
        .clk(clk),
        .reset(reset),
        .start(start),
        .opcode(opcode),
        .in1(in1),
        .in2(in2),
        .out_high(out_high),
        .out_low(out_low),
        .flag(flag),
        .done(done)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Done pulses counted mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (done) begin
            done_count = done_count + 1;
        end
    end

    // Poll done on falling edges for up to DONE_TIMEOUT cycles
    task automatic wait_for_done(output logic got_done);
        int cycles;
        cycles = 0;
        got_done = 1'b0;
        while (!got_done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (done) begin
                got_done = 1'b1;
            end
        end
    endtask

    // One start pulse and a compare of all three outputs
    task automatic run_test(input int op, input int a, input int b, input int exp_high,
                            input int exp_low, input int exp_flag, input string name);
        logic got_done;
        logic mismatch;
        @(posedge clk);
        #DRIVE_DELAY;
        opcode = op[OPCODE_W-1:0];
        in1 = a[WIDTH-1:0];
        in2 = b[WIDTH-1:0];
        start = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        wait_for_done(got_done);
        test_count = test_count + 1;
        if (!got_done) begin
            $display("Test %s timed out, no done within %0d cycles", name, DONE_TIMEOUT);
            fail_count = fail_count + 1;
            timed_out = 1'b1;
        end else begin
            mismatch = 1'b0;
            if (out_high !== exp_high[WIDTH-1:0]) begin
                mismatch = 1'b1;
            end
            if (out_low !== exp_low[WIDTH-1:0]) begin
                mismatch = 1'b1;
            end
            if (flag !== exp_flag[0]) begin
                mismatch = 1'b1;
            end
            if (mismatch) begin
                $write("FAILED %s: expected high=%0d low=%0d flag=%0d, ",
                       name, exp_high, exp_low, exp_flag);
                $display("actual high=%0d low=%0d flag=%0d", out_high, out_low, flag);
                fail_count = fail_count + 1;
            end else begin
                $display("ok %s", name);
                pass_count = pass_count + 1;
            end
        end
    endtask

    // Main sequence
    initial begin
        int fd;
        int fields;
        int op;
        int a;
        int b;
        int exp_high;
        int exp_low;
        int exp_flag;
        string line;
        string name;

        start = 1'b0;
        opcode = '0;
        in1 = '0;
        in2 = '0;
        reset = 1'b1;
        // Two cycles of reset
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        fd = $fopen("testbench/alu_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file testbench/alu_tests.txt");
            other_errors = other_errors + 1;
        end else begin
            // One line per test and lines starting with # are comments
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%d %d %d %d %d %d %s",
                                     op, a, b, exp_high, exp_low, exp_flag, name);
                    if (fields == 7) begin
                        run_test(op, a, b, exp_high, exp_low, exp_flag, name);
                    end else if (line.len() > 1) begin
                        $display("Malformed line in tests file: %s", line);
                        other_errors = other_errors + 1;
                    end
                end
            end
            $fclose(fd);
        end

        if (!timed_out) begin
            // Let any extra done show up
            repeat (DRAIN_CYCLES) @(negedge clk);
            if (test_count == 0) begin
                $display("No tests were read from the tests file");
                other_errors = other_errors + 1;
            end
            if (done_count != test_count) begin
                $display("Saw %0d done pulses for %0d tests", done_count, test_count);
                other_errors = other_errors + 1;
            end
        end

        $display("Tests: %0d passed, %0d failed, %0d other problems",
                 pass_count, fail_count, other_errors);
        if (fail_count == 0 && other_errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- testbench/alu_tests.txt
# Columns: opcode in1 in2 expected_out_high expected_out_low expected_flag test_name
# All numbers decimal; opcodes ADD 0 SUB 1 MUL 2 DIV 3 LT 6 GT 7 EQ 8 AND 9 OR 10 XOR 11 NOT 12
0 200 100 0 44 1 add_carry
0 15 27 0 42 0 add_small
0 255 1 0 0 1 add_wrap
0 0 0 0 0 0 add_zero
1 100 58 0 42 0 sub_plain
1 10 20 0 246 1 sub_borrow
1 77 77 0 0 0 sub_equal
1 0 255 0 1 1 sub_max_borrow
2 255 255 254 1 0 mul_max
2 123 0 0 0 0 mul_by_zero
2 12 13 0 156 0 mul_small
2 16 32 2 0 0 mul_shift
2 1 200 0 200 0 mul_one
3 100 7 14 2 0 div_plain
3 5 9 0 5 0 div_small_dividend
3 200 0 0 0 0 div_by_zero
3 255 1 255 0 0 div_by_one
3 255 16 15 15 0 div_remainder
9 240 204 0 192 0 and_mask
10 240 12 0 252 0 or_bits
11 170 255 0 85 0 xor_invert
12 90 0 0 165 0 not_in1
6 3 9 0 0 1 lt_true
6 9 3 0 0 0 lt_false
7 200 100 0 0 1 gt_true
7 50 50 0 0 0 gt_equal
8 66 66 0 0 1 eq_true
8 66 67 0 0 0 eq_false
5 12 34 0 0 0 unsupported_5
15 255 255 0 0 0 unsupported_15
2 3 4 0 12 0 mul_after_unsupported
11 15 60 0 51 0 xor_after_mul
3 77 8 9 5 0 div_after_xor
1 3 1 0 2 0 sub_after_div
